/* include/core_if_defines.svh */
// Width and depth macros of the core interface bridge
`ifndef CORE_IF_DEFINES_SVH
`define CORE_IF_DEFINES_SVH

// Task identifier carried with every data request
`define CORE_IF_TID_W 14

// Address, page-directory pointer and write data
`define CORE_IF_ADDR_W 32

// Data returned by the memory side
`define CORE_IF_RDATA_W 64

// Interrupt number from the interrupt source
`define CORE_IF_IRQ_W 6

// Entries per crossing FIFO
`define CORE_IF_FIFO_DEPTH 4

// Entry index bits, one bit narrower than the gray pointer
`define CORE_IF_PTR_W 2

`endif

/* logic/core_if_pkg.sv */
// Bridge types for access order, request payload and FSM state encodings
`include "core_if_defines.svh"

package core_if_pkg;

	// Access size of a data request
	typedef enum logic [1:0] {
		order_byte = 2'h0,
		order_half = 2'h1,
		order_word = 2'h2,
		order_none = 2'h3
	} access_order_t;

	// One data request as it crosses into the interface domain
	// 2 + 1 + 14 + 2 + 32 + 32 + 32 = 115 bits
	typedef struct packed {
		access_order_t order;
		// 1 for read, 0 for write
		logic rw;
		logic [`CORE_IF_TID_W-1:0] tid;
		logic [1:0] mmumod;
		logic [`CORE_IF_ADDR_W-1:0] pdt;
		logic [`CORE_IF_ADDR_W-1:0] addr;
		logic [`CORE_IF_ADDR_W-1:0] wdata;
	} mem_request_t;

	// IOSR qualification steps
	typedef enum logic [1:0] {
		iosr_wait = 2'h0,
		iosr_can1 = 2'h1,
		iosr_can2 = 2'h2,
		iosr_get = 2'h3
	} iosr_state_t;

	// Shared by both interrupt FSMs
	typedef enum logic {
		irq_idle = 1'b0,
		irq_pending = 1'b1
	} irq_state_t;

endpackage

/* logic/async_fifo_if.sv */
// Write and read signal bundle of one dual-clock FIFO with its modports
`timescale 1ns/100ps

interface async_fifo_if #(
	parameter int WIDTH = 1
);
	// Write side, source clock
	logic wr_en;
	logic [WIDTH-1:0] wr_data;
	logic full;

	// Read side, destination clock
	logic rd_en;
	logic [WIDTH-1:0] rd_data;
	logic empty;

	// Producer view
	modport writer (output wr_en, output wr_data, input full);
	// Consumer view with show-ahead data
	modport reader (output rd_en, input rd_data, input empty);
	// The FIFO itself
	modport fifo (input wr_en, input wr_data, output full,
		input rd_en, output rd_data, output empty);

endinterface

/* logic/async_fifo.sv */
// Dual-clock show-ahead FIFO with gray pointers and two-flop synchronizers
`timescale 1ns/100ps
`include "core_if_defines.svh"

module async_fifo #(
	parameter int WIDTH = 1
) (
	input logic wr_clock,
	input logic rd_clock,
	input logic inRESET,
	async_fifo_if.fifo port
);
	localparam int DEPTH = `CORE_IF_FIFO_DEPTH;
	localparam int PTR_W = `CORE_IF_PTR_W;

	logic [WIDTH-1:0] mem [DEPTH];

	// Write domain pointers with one extra bit for wrap
	logic [PTR_W:0] wr_bin;
	logic [PTR_W:0] wr_bin_next;
	logic [PTR_W:0] wr_gray;
	logic [PTR_W:0] wr_gray_next;
	// Read pointer seen from the write domain
	logic [PTR_W:0] rd_gray_w1;
	logic [PTR_W:0] rd_gray_w2;
	logic full_q;
	logic wr_go;

	// Read domain pointers
	logic [PTR_W:0] rd_bin;
	logic [PTR_W:0] rd_bin_next;
	logic [PTR_W:0] rd_gray;
	logic [PTR_W:0] rd_gray_next;
	// Write pointer seen from the read domain
	logic [PTR_W:0] wr_gray_r1;
	logic [PTR_W:0] wr_gray_r2;
	logic empty_q;
	logic rd_go;

	// Write while full is dropped
	assign wr_go = port.wr_en && !full_q;
	assign wr_bin_next = wr_bin + {{PTR_W{1'b0}}, wr_go};
	assign wr_gray_next = (wr_bin_next >> 1) ^ wr_bin_next;

	always_ff @(posedge wr_clock or negedge inRESET) begin
		if (!inRESET) begin
			wr_bin <= '0;
			wr_gray <= '0;
			rd_gray_w1 <= '0;
			rd_gray_w2 <= '0;
			full_q <= 1'b0;
		end else begin
			wr_bin <= wr_bin_next;
			wr_gray <= wr_gray_next;
			rd_gray_w1 <= rd_gray;
			rd_gray_w2 <= rd_gray_w1;
			// Full when the two top gray bits differ and the rest match
			full_q <= (wr_gray_next ==
				{~rd_gray_w2[PTR_W:PTR_W-1], rd_gray_w2[PTR_W-2:0]});
		end
	end

	// Storage
	always_ff @(posedge wr_clock) begin
		if (wr_go) begin
			mem[wr_bin[PTR_W-1:0]] <= port.wr_data;
		end
	end

	// Pop only a present head
	assign rd_go = port.rd_en && !empty_q;
	assign rd_bin_next = rd_bin + {{PTR_W{1'b0}}, rd_go};
	assign rd_gray_next = (rd_bin_next >> 1) ^ rd_bin_next;

	always_ff @(posedge rd_clock or negedge inRESET) begin
		if (!inRESET) begin
			rd_bin <= '0;
			rd_gray <= '0;
			wr_gray_r1 <= '0;
			wr_gray_r2 <= '0;
			empty_q <= 1'b1;
		end else begin
			rd_bin <= rd_bin_next;
			rd_gray <= rd_gray_next;
			wr_gray_r1 <= wr_gray;
			wr_gray_r2 <= wr_gray_r1;
			empty_q <= (rd_gray_next == wr_gray_r2);
		end
	end

	// Head of queue shown whenever not empty
	assign port.rd_data = mem[rd_bin[PTR_W-1:0]];
	assign port.full = full_q;
	assign port.empty = empty_q;

endmodule

/* logic/request_channel.sv */
// Data request crossing from the core clock to the interface clock under lock
`timescale 1ns/100ps

module request_channel (
	input logic iCORE_CLOCK,
	input logic if_clock,
	input logic inRESET,
	input logic core_data_req,
	input core_if_pkg::mem_request_t core_request,
	output logic core_data_lock,
	input logic mem_lock,
	output logic mem_req,
	output core_if_pkg::mem_request_t mem_request
);
	localparam int REQ_W = $bits(core_if_pkg::mem_request_t);

	async_fifo_if #(.WIDTH(REQ_W)) req_if ();

	async_fifo #(.WIDTH(REQ_W)) req_fifo (
		.wr_clock(iCORE_CLOCK),
		.rd_clock(if_clock),
		.inRESET(inRESET),
		.port(req_if.fifo)
	);

	// Core side writes one entry per request strobe
	assign req_if.wr_en = core_data_req;
	assign req_if.wr_data = core_request;
	// Full FIFO stalls the core
	assign core_data_lock = req_if.full;

	// Lock on the interface side holds entries back
	assign req_if.rd_en = !mem_lock && !req_if.empty;
	assign mem_req = req_if.rd_en;
	assign mem_request = core_if_pkg::mem_request_t'(req_if.rd_data);

endmodule

/* logic/response_channel.sv */
// Read data crossing from the interface clock back to the core clock
`timescale 1ns/100ps
`include "core_if_defines.svh"

module response_channel (
	input logic iCORE_CLOCK,
	input logic if_clock,
	input logic inRESET,
	input logic mem_valid,
	input logic [`CORE_IF_RDATA_W-1:0] mem_rdata,
	output logic core_data_valid,
	output logic [`CORE_IF_RDATA_W-1:0] core_data_rdata
);
	async_fifo_if #(.WIDTH(`CORE_IF_RDATA_W)) rsp_if ();

	async_fifo #(.WIDTH(`CORE_IF_RDATA_W)) rsp_fifo (
		.wr_clock(if_clock),
		.rd_clock(iCORE_CLOCK),
		.inRESET(inRESET),
		.port(rsp_if.fifo)
	);

	// No back-pressure toward memory
	assign rsp_if.wr_en = mem_valid;
	assign rsp_if.wr_data = mem_rdata;

	// Drain one entry per core cycle
	assign rsp_if.rd_en = !rsp_if.empty;
	assign core_data_valid = !rsp_if.empty;
	assign core_data_rdata = rsp_if.rd_data;

endmodule

/* logic/irq_handshake.sv */
// Interrupt handshake with interface and core FSMs and number and token FIFOs
`timescale 1ns/100ps
`include "core_if_defines.svh"

module irq_handshake (
	input logic iCORE_CLOCK,
	input logic if_clock,
	input logic inRESET,
	input logic interrupt_valid,
	input logic [`CORE_IF_IRQ_W-1:0] interrupt_num,
	output logic interrupt_ack,
	output logic core_irq_valid,
	output logic [`CORE_IF_IRQ_W-1:0] core_irq_num,
	input logic core_irq_ack
);
	// Number toward the core, token back toward the source
	async_fifo_if #(.WIDTH(`CORE_IF_IRQ_W)) num_if ();
	async_fifo_if #(.WIDTH(1)) tok_if ();

	async_fifo #(.WIDTH(`CORE_IF_IRQ_W)) num_fifo (
		.wr_clock(if_clock),
		.rd_clock(iCORE_CLOCK),
		.inRESET(inRESET),
		.port(num_if.fifo)
	);

	async_fifo #(.WIDTH(1)) tok_fifo (
		.wr_clock(iCORE_CLOCK),
		.rd_clock(if_clock),
		.inRESET(inRESET),
		.port(tok_if.fifo)
	);

	core_if_pkg::irq_state_t if_state;
	core_if_pkg::irq_state_t core_state;
	logic if_push;
	logic [`CORE_IF_IRQ_W-1:0] if_num;
	logic ack_q;
	logic tok_ready;

	// Interface side
	assign tok_ready = !tok_if.empty && tok_if.rd_data[0];
	assign tok_if.rd_en = (if_state == core_if_pkg::irq_pending) && tok_ready;
	assign num_if.wr_en = if_push;
	assign num_if.wr_data = if_num;
	assign interrupt_ack = ack_q;

	always_ff @(posedge if_clock or negedge inRESET) begin
		if (!inRESET) begin
			if_state <= core_if_pkg::irq_idle;
			if_push <= 1'b0;
			if_num <= '0;
			ack_q <= 1'b0;
		end else begin
			// Push and ack are single-cycle strobes
			if_push <= 1'b0;
			ack_q <= 1'b0;
			case (if_state)
				core_if_pkg::irq_idle: begin
					if (interrupt_valid) begin
						if_push <= 1'b1;
						if_num <= interrupt_num;
						if_state <= core_if_pkg::irq_pending;
					end
				end
				core_if_pkg::irq_pending: begin
					// New requests ignored until the token returns
					if (tok_if.rd_en) begin
						ack_q <= 1'b1;
						if_state <= core_if_pkg::irq_idle;
					end
				end
			endcase
		end
	end

	// Core side
	assign num_if.rd_en = (core_state == core_if_pkg::irq_idle) && !num_if.empty;
	assign tok_if.wr_en = (core_state == core_if_pkg::irq_pending) && core_irq_ack;
	assign tok_if.wr_data = 1'b1;
	assign core_irq_valid = (core_state == core_if_pkg::irq_pending);

	always_ff @(posedge iCORE_CLOCK or negedge inRESET) begin
		if (!inRESET) begin
			core_state <= core_if_pkg::irq_idle;
			core_irq_num <= '0;
		end else begin
			case (core_state)
				core_if_pkg::irq_idle: begin
					if (num_if.rd_en) begin
						core_irq_num <= num_if.rd_data;
						core_state <= core_if_pkg::irq_pending;
					end
				end
				core_if_pkg::irq_pending: begin
					// Valid drops the cycle after the ack
					if (core_irq_ack) begin
						core_state <= core_if_pkg::irq_idle;
					end
				end
			endcase
		end
	end

endmodule

/* logic/iosr_capture.sv */
// IOSR qualification over four consecutive valid cycles and hold until reset
`timescale 1ns/100ps
`include "core_if_defines.svh"

module iosr_capture (
	input logic iCORE_CLOCK,
	input logic inRESET,
	input logic sysinfo_iosr_valid,
	input logic [`CORE_IF_ADDR_W-1:0] sysinfo_iosr,
	output logic iosr_valid,
	output logic [`CORE_IF_ADDR_W-1:0] iosr
);
	core_if_pkg::iosr_state_t state;

	always_ff @(posedge iCORE_CLOCK or negedge inRESET) begin
		if (!inRESET) begin
			state <= core_if_pkg::iosr_wait;
			iosr_valid <= 1'b0;
			iosr <= '0;
		end else if (!iosr_valid) begin
			// Any low cycle restarts the count
			if (!sysinfo_iosr_valid) begin
				state <= core_if_pkg::iosr_wait;
			end else begin
				case (state)
					core_if_pkg::iosr_wait: state <= core_if_pkg::iosr_can1;
					core_if_pkg::iosr_can1: state <= core_if_pkg::iosr_can2;
					core_if_pkg::iosr_can2: state <= core_if_pkg::iosr_get;
					core_if_pkg::iosr_get: begin
						// Sample of the fourth high cycle is kept
						iosr <= sysinfo_iosr;
						iosr_valid <= 1'b1;
					end
				endcase
			end
		end
		// Once valid, value and flag stay put
	end

endmodule

/* logic/core_if_bridge.sv */
// Top level of the core to interface clock bridge
`timescale 1ns/100ps
`include "core_if_defines.svh"

module core_if_bridge (
	input logic iCORE_CLOCK,
	input logic if_clock,
	input logic inRESET,
	// Core data requests
	input logic core_data_req,
	input logic [1:0] core_data_order,
	input logic core_data_rw,
	input logic [`CORE_IF_TID_W-1:0] core_data_tid,
	input logic [1:0] core_data_mmumod,
	input logic [`CORE_IF_ADDR_W-1:0] core_data_pdt,
	input logic [`CORE_IF_ADDR_W-1:0] core_data_addr,
	input logic [`CORE_IF_ADDR_W-1:0] core_data_wdata,
	output logic core_data_lock,
	// Core read return
	output logic core_data_valid,
	output logic [`CORE_IF_RDATA_W-1:0] core_data_rdata,
	// Core interrupt
	output logic core_irq_valid,
	output logic [`CORE_IF_IRQ_W-1:0] core_irq_num,
	input logic core_irq_ack,
	// Qualified system information
	output logic iosr_valid,
	output logic [`CORE_IF_ADDR_W-1:0] iosr,
	// Memory side requests
	output logic mem_req,
	input logic mem_lock,
	output logic [1:0] mem_order,
	output logic mem_rw,
	output logic [`CORE_IF_TID_W-1:0] mem_tid,
	output logic [1:0] mem_mmumod,
	output logic [`CORE_IF_ADDR_W-1:0] mem_pdt,
	output logic [`CORE_IF_ADDR_W-1:0] mem_addr,
	output logic [`CORE_IF_ADDR_W-1:0] mem_wdata,
	// Memory side return
	input logic mem_valid,
	input logic [`CORE_IF_RDATA_W-1:0] mem_rdata,
	// Interrupt source
	input logic interrupt_valid,
	input logic [`CORE_IF_IRQ_W-1:0] interrupt_num,
	output logic interrupt_ack,
	// System information
	input logic sysinfo_iosr_valid,
	input logic [`CORE_IF_ADDR_W-1:0] sysinfo_iosr
);
	core_if_pkg::mem_request_t core_request;
	core_if_pkg::mem_request_t mem_request;

	// Request payload packing
	assign core_request.order = core_if_pkg::access_order_t'(core_data_order);
	assign core_request.rw = core_data_rw;
	assign core_request.tid = core_data_tid;
	assign core_request.mmumod = core_data_mmumod;
	assign core_request.pdt = core_data_pdt;
	assign core_request.addr = core_data_addr;
	assign core_request.wdata = core_data_wdata;

	// Unpacked on the memory side
	assign mem_order = mem_request.order;
	assign mem_rw = mem_request.rw;
	assign mem_tid = mem_request.tid;
	assign mem_mmumod = mem_request.mmumod;
	assign mem_pdt = mem_request.pdt;
	assign mem_addr = mem_request.addr;
	assign mem_wdata = mem_request.wdata;

	request_channel req_ch (
		.iCORE_CLOCK(iCORE_CLOCK),
		.if_clock(if_clock),
		.inRESET(inRESET),
		.core_data_req(core_data_req),
		.core_request(core_request),
		.core_data_lock(core_data_lock),
		.mem_lock(mem_lock),
		.mem_req(mem_req),
		.mem_request(mem_request)
	);

	response_channel rsp_ch (
		.iCORE_CLOCK(iCORE_CLOCK),
		.if_clock(if_clock),
		.inRESET(inRESET),
		.mem_valid(mem_valid),
		.mem_rdata(mem_rdata),
		.core_data_valid(core_data_valid),
		.core_data_rdata(core_data_rdata)
	);

	irq_handshake irq_hs (
		.iCORE_CLOCK(iCORE_CLOCK),
		.if_clock(if_clock),
		.inRESET(inRESET),
		.interrupt_valid(interrupt_valid),
		.interrupt_num(interrupt_num),
		.interrupt_ack(interrupt_ack),
		.core_irq_valid(core_irq_valid),
		.core_irq_num(core_irq_num),
		.core_irq_ack(core_irq_ack)
	);

	iosr_capture iosr_cap (
		.iCORE_CLOCK(iCORE_CLOCK),
		.inRESET(inRESET),
		.sysinfo_iosr_valid(sysinfo_iosr_valid),
		.sysinfo_iosr(sysinfo_iosr),
		.iosr_valid(iosr_valid),
		.iosr(iosr)
	);

endmodule

/* tests/core_if_checker.sv */
// Concurrent assertions on lock, ack pulse, IOSR and irq stability of the bridge top level
`timescale 1ns/100ps
`include "core_if_defines.svh"

module core_if_checker (
	input logic iCORE_CLOCK,
	input logic if_clock,
	input logic inRESET,
	input logic mem_req,
	input logic mem_lock,
	input logic interrupt_ack,
	input logic iosr_valid,
	input logic [`CORE_IF_ADDR_W-1:0] iosr,
	input logic core_irq_valid,
	input logic [`CORE_IF_IRQ_W-1:0] core_irq_num
);
	// Read back by the testbench top
	int fails = 0;

	// No request leaves while memory is locked
	req_under_lock: assert property (@(posedge if_clock) disable iff (!inRESET)
		!(mem_req && mem_lock))
		else begin
			fails++;
			$error("mem_req high while mem_lock high");
		end

	// Ack toward the source lasts one cycle
	ack_pulse: assert property (@(posedge if_clock) disable iff (!inRESET)
		interrupt_ack |=> !interrupt_ack)
		else begin
			fails++;
			$error("interrupt_ack longer than one cycle");
		end

	// Latched IOSR never moves
	iosr_hold: assert property (@(posedge iCORE_CLOCK) disable iff (!inRESET)
		iosr_valid |=> iosr_valid && $stable(iosr))
		else begin
			fails++;
			$error("iosr changed after iosr_valid");
		end

	// Number stays put while shown to the core
	irq_num_hold: assert property (@(posedge iCORE_CLOCK) disable iff (!inRESET)
		core_irq_valid |=> !core_irq_valid || $stable(core_irq_num))
		else begin
			fails++;
			$error("core_irq_num changed while core_irq_valid");
		end

endmodule

/* tests/core_if_monitor.sv */
// Reference model and comparisons of the bridge, per-test result lines
`timescale 1ns/100ps
`include "core_if_defines.svh"

module core_if_monitor #(
	parameter int REQ_W = 5 + `CORE_IF_TID_W + 3 * `CORE_IF_ADDR_W
) (
	input logic iCORE_CLOCK,
	input logic if_clock,
	input logic inRESET,
	input logic core_data_req,
	input logic core_data_lock,
	input logic [REQ_W-1:0] core_req_bits,
	input logic mem_req,
	input logic mem_lock,
	input logic [REQ_W-1:0] mem_req_bits,
	input logic mem_valid,
	input logic [`CORE_IF_RDATA_W-1:0] mem_rdata,
	input logic core_data_valid,
	input logic [`CORE_IF_RDATA_W-1:0] core_data_rdata,
	input logic interrupt_valid,
	input logic [`CORE_IF_IRQ_W-1:0] interrupt_num,
	input logic interrupt_ack,
	input logic core_irq_valid,
	input logic [`CORE_IF_IRQ_W-1:0] core_irq_num,
	input logic core_irq_ack,
	input logic sysinfo_iosr_valid,
	input logic [`CORE_IF_ADDR_W-1:0] sysinfo_iosr,
	input logic iosr_valid,
	input logic [`CORE_IF_ADDR_W-1:0] iosr
);
	int errors = 0;
	int tests = 0;
	int failed_tests = 0;
	int test_start = 0;
	int irq_count = 0;
	int core_acks = 0;
	int if_acks = 0;

	// Requests accepted, returns sent, interrupts captured
	logic [REQ_W-1:0] req_q[$];
	logic [`CORE_IF_RDATA_W-1:0] rsp_q[$];
	logic [`CORE_IF_IRQ_W-1:0] irq_q[$];
	logic irq_busy = 1'b0;
	logic irq_shown = 1'b0;
	// IOSR model
	int run = 0;
	logic iosr_latched = 1'b0;
	logic [`CORE_IF_ADDR_W-1:0] iosr_exp = '0;

	task automatic mismatch(input string name, input logic [127:0] exp,
		input logic [127:0] act);
		$display("Fail t=%0t %s expected %0h got %0h", $time, name, exp, act);
		errors++;
	endtask

	task automatic flag(input string msg);
		$display("Error t=%0t %s", $time, msg);
		errors++;
	endtask

	task automatic end_test(input string name);
		tests++;
		if (errors != test_start) begin
			failed_tests++;
			$display("Test %s: FAIL with %0d errors", name, errors - test_start);
		end else begin
			$display("Test %s: pass", name);
		end
		test_start = errors;
	endtask

	// Nothing in flight on any path
	function automatic logic idle();
		return req_q.size() == 0 && rsp_q.size() == 0 && irq_q.size() == 0
			&& !irq_busy && !irq_shown && core_acks == if_acks;
	endfunction

	task automatic final_checks();
		if (!idle())
			flag("transactions still outstanding at the end");
		if (!iosr_valid)
			flag("iosr_valid never rose");
	endtask

	// Outputs right after reset release
	always @(posedge inRESET) begin
		if ({mem_req, core_data_lock, core_data_valid, core_irq_valid, interrupt_ack,
			iosr_valid} !== 6'b0)
			mismatch("reset outputs", 0, {mem_req, core_data_lock, core_data_valid,
				core_irq_valid, interrupt_ack, iosr_valid});
	end

	// Interface clock side
	always @(posedge if_clock) begin
		if (inRESET) begin
			if (mem_req && mem_lock)
				flag("mem_req high while mem_lock high");
			if (mem_req) begin
				if (req_q.size() == 0)
					flag("mem_req with no request outstanding");
				else if (mem_req_bits !== req_q[0])
					mismatch("mem request", req_q[0], mem_req_bits);
				if (req_q.size() != 0)
					void'(req_q.pop_front());
			end
			if (mem_valid)
				rsp_q.push_back(mem_rdata);
			// Ack frees the source side first
			if (interrupt_ack) begin
				if (!irq_busy || if_acks >= core_acks)
					flag("interrupt_ack without core acknowledge");
				else
					if_acks++;
				irq_busy = 1'b0;
			end
			if (!irq_busy && interrupt_valid) begin
				irq_q.push_back(interrupt_num);
				irq_busy = 1'b1;
				irq_count++;
			end
		end
	end

	// Core clock side
	always @(posedge iCORE_CLOCK) begin
		if (inRESET) begin
			// The core only strobes with the lock low, so every strobe is owed
			if (core_data_req) begin
				if (core_data_lock)
					flag("request strobe met a raised core_data_lock");
				req_q.push_back(core_req_bits);
			end
			if (core_data_valid) begin
				if (rsp_q.size() == 0)
					flag("core_data_valid with no return outstanding");
				else if (core_data_rdata !== rsp_q[0])
					mismatch("core_data_rdata", rsp_q[0], core_data_rdata);
				if (rsp_q.size() != 0)
					void'(rsp_q.pop_front());
			end
			if (irq_shown && !core_irq_valid)
				flag("core_irq_valid dropped before acknowledge");
			if (core_irq_valid && !irq_shown) begin
				if (irq_q.size() == 0)
					flag("core_irq_valid with no interrupt captured");
				else if (core_irq_num !== irq_q[0])
					mismatch("core_irq_num", irq_q[0], core_irq_num);
				if (irq_q.size() != 0)
					void'(irq_q.pop_front());
				irq_shown = 1'b1;
			end
			if (core_irq_valid && core_irq_ack) begin
				core_acks++;
				irq_shown = 1'b0;
			end
			// IOSR compared before the model steps
			if (iosr_valid !== iosr_latched)
				mismatch("iosr_valid", iosr_latched, iosr_valid);
			else if (iosr_latched && iosr !== iosr_exp)
				mismatch("iosr", iosr_exp, iosr);
			if (!iosr_latched) begin
				if (!sysinfo_iosr_valid) begin
					run = 0;
				end else if (run == 3) begin
					iosr_latched = 1'b1;
					iosr_exp = sysinfo_iosr;
				end else begin
					run++;
				end
			end
		end
	end

endmodule

/* tests/core_if_tb.sv */
// Bridge testbench with clocks, reset, seeded stimulus, memory and irq source, timeout
`timescale 1ns/100ps
`include "core_if_defines.svh"

module core_if_tb;
	// Transaction count over all tests sets the timeout
	localparam int N_TRANS = 200 + 8 + 40 + 20 + 10;
	localparam int LIMIT = 30 * N_TRANS + 2000;

	// Edges of the two clocks never coincide
	logic iCORE_CLOCK = 1'b1;
	logic if_clock = 1'b0;
	logic inRESET;
	logic core_data_req;
	logic [1:0] core_data_order;
	logic core_data_rw;
	logic [`CORE_IF_TID_W-1:0] core_data_tid;
	logic [1:0] core_data_mmumod;
	logic [`CORE_IF_ADDR_W-1:0] core_data_pdt;
	logic [`CORE_IF_ADDR_W-1:0] core_data_addr;
	logic [`CORE_IF_ADDR_W-1:0] core_data_wdata;
	logic core_data_lock;
	logic core_data_valid;
	logic [`CORE_IF_RDATA_W-1:0] core_data_rdata;
	logic core_irq_valid;
	logic [`CORE_IF_IRQ_W-1:0] core_irq_num;
	logic core_irq_ack;
	logic iosr_valid;
	logic [`CORE_IF_ADDR_W-1:0] iosr;
	logic mem_req;
	logic mem_lock;
	logic [1:0] mem_order;
	logic mem_rw;
	logic [`CORE_IF_TID_W-1:0] mem_tid;
	logic [1:0] mem_mmumod;
	logic [`CORE_IF_ADDR_W-1:0] mem_pdt;
	logic [`CORE_IF_ADDR_W-1:0] mem_addr;
	logic [`CORE_IF_ADDR_W-1:0] mem_wdata;
	logic mem_valid;
	logic [`CORE_IF_RDATA_W-1:0] mem_rdata;
	logic interrupt_valid;
	logic [`CORE_IF_IRQ_W-1:0] interrupt_num;
	logic interrupt_ack;
	logic sysinfo_iosr_valid;
	logic [`CORE_IF_ADDR_W-1:0] sysinfo_iosr;

	integer seed = 32'ha41f;
	int cycles = 0;
	int ack_wait = 0;
	// Environment modes
	logic lock_random = 1'b0;
	logic hold_lock = 1'b0;
	logic irq_run = 1'b0;

	always #50 iCORE_CLOCK = ~iCORE_CLOCK;
	always #70 if_clock = ~if_clock;

	core_if_bridge dut0 (.*);

	bind core_if_bridge core_if_checker chk0 (.*);

	core_if_monitor monitor0 (
		.core_req_bits({core_data_order, core_data_rw, core_data_tid, core_data_mmumod,
			core_data_pdt, core_data_addr, core_data_wdata}),
		.mem_req_bits({mem_order, mem_rw, mem_tid, mem_mmumod, mem_pdt, mem_addr,
			mem_wdata}),
		.*
	);

	// Memory model with random lock and one return per read
	always @(posedge if_clock) begin
		mem_valid <= 1'b0;
		if (mem_req && mem_rw) begin
			mem_valid <= 1'b1;
			mem_rdata <= {mem_addr ^ 32'h5a5a_0f0f, ~mem_addr};
		end
		mem_lock <= hold_lock || (lock_random && (($random(seed) & 3) == 0));
	end

	// Interrupt source
	always @(posedge if_clock) begin
		interrupt_valid <= irq_run && (($random(seed) & 3) == 0);
		interrupt_num <= $random(seed);
	end

	// One-cycle core acknowledge after a random delay
	always @(posedge iCORE_CLOCK) begin
		if (core_irq_ack) begin
			core_irq_ack <= 1'b0;
		end else if (core_irq_valid) begin
			if (ack_wait == 0) begin
				core_irq_ack <= 1'b1;
				ack_wait <= $random(seed) & 7;
			end else begin
				ack_wait <= ack_wait - 1;
			end
		end
	end

	// Run limit
	always @(posedge iCORE_CLOCK) begin
		cycles++;
		if (cycles >= LIMIT) begin
			$display("Timeout: run stopped after %0d core cycles", cycles);
			$display("Simulation failed");
			$finish;
		end
	end

	// One request held back while locked and followed by one idle cycle
	task automatic send_request(input logic read);
		@(posedge iCORE_CLOCK);
		while (core_data_lock)
			@(posedge iCORE_CLOCK);
		core_data_req <= 1'b1;
		core_data_order <= $random(seed);
		core_data_rw <= read;
		core_data_tid <= $random(seed);
		core_data_mmumod <= $random(seed);
		core_data_pdt <= $random(seed);
		core_data_addr <= $random(seed);
		core_data_wdata <= $random(seed);
		@(posedge iCORE_CLOCK);
		core_data_req <= 1'b0;
	endtask

	task automatic wait_quiet();
		int quiet;
		quiet = 0;
		while (quiet < 12) begin
			@(posedge iCORE_CLOCK);
			if (monitor0.idle() && !mem_valid && !core_data_valid)
				quiet++;
			else
				quiet = 0;
		end
	endtask

	task automatic iosr_burst(input int len);
		repeat (len) begin
			@(posedge iCORE_CLOCK);
			sysinfo_iosr_valid <= 1'b1;
			sysinfo_iosr <= $random(seed);
		end
		@(posedge iCORE_CLOCK);
		sysinfo_iosr_valid <= 1'b0;
		@(posedge iCORE_CLOCK);
	endtask

	initial begin
		logic got_lock;
		inRESET = 1'b0;
		core_data_req = 1'b0;
		core_data_order = '0;
		core_data_rw = 1'b0;
		core_data_tid = '0;
		core_data_mmumod = '0;
		core_data_pdt = '0;
		core_data_addr = '0;
		core_data_wdata = '0;
		core_irq_ack = 1'b0;
		mem_lock = 1'b0;
		mem_valid = 1'b0;
		mem_rdata = '0;
		interrupt_valid = 1'b0;
		interrupt_num = '0;
		sysinfo_iosr_valid = 1'b0;
		sysinfo_iosr = '0;

		repeat (10) @(posedge iCORE_CLOCK);
		inRESET <= 1'b1;
		repeat (3) @(posedge iCORE_CLOCK);
		monitor0.end_test("reset");

		lock_random = 1'b1;
		repeat (200) send_request($random(seed));
		wait_quiet();
		monitor0.end_test("request crossing");

		// Locked memory lets the FIFO fill and stall the core
		lock_random = 1'b0;
		hold_lock = 1'b1;
		repeat (4) @(posedge iCORE_CLOCK);
		repeat (4) send_request($random(seed));
		got_lock = 1'b0;
		repeat (12) begin
			@(posedge iCORE_CLOCK);
			if (core_data_lock)
				got_lock = 1'b1;
		end
		if (!got_lock)
			monitor0.flag("core_data_lock did not rise after four held requests");
		hold_lock = 1'b0;
		wait_quiet();
		monitor0.end_test("back-pressure");

		lock_random = 1'b1;
		repeat (40) send_request(1'b1);
		wait_quiet();
		monitor0.end_test("read return");

		irq_run = 1'b1;
		while (monitor0.irq_count < 20)
			@(posedge iCORE_CLOCK);
		irq_run = 1'b0;
		wait_quiet();
		monitor0.end_test("interrupt round trip");

		// Short bursts before the qualifying runs
		iosr_burst(1);
		iosr_burst(3);
		iosr_burst(2);
		iosr_burst(1);
		iosr_burst(6);
		iosr_burst(3);
		iosr_burst(5);
		monitor0.end_test("iosr qualification");

		monitor0.final_checks();
		$display("Tests run %0d, failed %0d, check errors %0d, assertion failures %0d",
			monitor0.tests, monitor0.failed_tests, monitor0.errors, dut0.chk0.fails);
		if (monitor0.errors == 0 && dut0.chk0.fails == 0)
			$display("Simulation completed successfully");
		else
			$display("Simulation failed");
		$finish;
	end

endmodule

/* filelist.f */
+incdir+include
logic/core_if_pkg.sv
logic/async_fifo_if.sv
logic/async_fifo.sv
logic/request_channel.sv
logic/response_channel.sv
logic/irq_handshake.sv
logic/iosr_capture.sv
logic/core_if_bridge.sv
tests/core_if_checker.sv
tests/core_if_monitor.sv
tests/core_if_tb.sv

/* Bender.yml */
package:
  name: core_if_bridge

sources:
  - include_dirs:
      - include
    files:
      - logic/core_if_pkg.sv
      - logic/async_fifo_if.sv
      - logic/async_fifo.sv
      - logic/request_channel.sv
      - logic/response_channel.sv
      - logic/irq_handshake.sv
      - logic/iosr_capture.sv
      - logic/core_if_bridge.sv
  - target: test
    include_dirs:
      - include
    files:
      - tests/core_if_checker.sv
      - tests/core_if_monitor.sv
      - tests/core_if_tb.sv
